//--- source/lcd_timing_pkg.sv
package lcd_timing_pkg;

    // pixel coordinate width, covers the visible area of the panel
    localparam int COORD_W = 9;                 // 0..511, enough for 480x272 active

    // 480x272 panel, horizontal timing in pixel clocks
    localparam int DEF_H_ACTIVE = 480;          // visible pixels per line
    localparam int DEF_H_FRONT  = 8;            // front porch
    localparam int DEF_H_SYNC   = 4;            // hsync pulse width
    localparam int DEF_H_BACK   = 43;           // back porch

    // vertical timing in lines
    localparam int DEF_V_ACTIVE = 272;          // visible lines per frame
    localparam int DEF_V_FRONT  = 8;            // front porch
    localparam int DEF_V_SYNC   = 4;            // vsync pulse width
    localparam int DEF_V_BACK   = 12;           // back porch

endpackage

//--- source/text_pkg.sv
package text_pkg;

    // cell geometry, 8x8 pixels per character cell
    localparam int CELL_BITS = 3;               // log2 of cell width and height

    // character buffer shape
    localparam int CHAR_W     = 8;              // one byte per cell
    localparam int BUF_ADDR_W = 12;             // {row[5:0], col[5:0]}, 64x64 cells

    // character byte fields
    localparam int INV_BIT   = 7;               // inverse video
    localparam int GLYPH_LSB = 0;               // glyph index low bit
    localparam int GLYPH_MSB = 3;               // glyph index high bit, 16 glyphs
    localparam int RANGE_LSB = 4;               // out-of-font field low bit
    localparam int RANGE_MSB = 6;               // nonzero here means blank cell

    // font image, 64-bit word per glyph, row 0 in the top byte
    localparam string FONT_FILE = "source/font_8x8.mem";

endpackage

//--- source/lcd_timing_gen.sv
`timescale 1ns/10ps

module lcd_timing_gen #(
    parameter int H_ACTIVE = lcd_timing_pkg::DEF_H_ACTIVE, // visible pixels
    parameter int H_FRONT  = lcd_timing_pkg::DEF_H_FRONT,  // h front porch
    parameter int H_SYNC   = lcd_timing_pkg::DEF_H_SYNC,   // hsync width
    parameter int H_BACK   = lcd_timing_pkg::DEF_H_BACK,   // h back porch
    parameter int V_ACTIVE = lcd_timing_pkg::DEF_V_ACTIVE, // visible lines
    parameter int V_FRONT  = lcd_timing_pkg::DEF_V_FRONT,  // v front porch
    parameter int V_SYNC   = lcd_timing_pkg::DEF_V_SYNC,   // vsync width in lines
    parameter int V_BACK   = lcd_timing_pkg::DEF_V_BACK    // v back porch
) (
    input  logic                               i_clk,      // pixel clock
    input  logic                               i_rst_n,    // sync reset, active low
    output logic [lcd_timing_pkg::COORD_W-1:0] o_x,        // horizontal position
    output logic [lcd_timing_pkg::COORD_W-1:0] o_y,        // vertical position
    output logic                               o_hsync,    // active high
    output logic                               o_vsync,    // active high
    output logic                               o_de        // active area
);
    import lcd_timing_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // clocks per line
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // lines per frame
    localparam int H_CW    = $clog2(H_TOTAL);                      // h counter width
    localparam int V_CW    = $clog2(V_TOTAL);                      // v counter width

    // porch boundaries at counter width
    localparam logic [H_CW-1:0] H_LAST    = H_CW'(H_TOTAL - 1);
    localparam logic [H_CW-1:0] H_ACT_END = H_CW'(H_ACTIVE);
    localparam logic [H_CW-1:0] HS_START  = H_CW'(H_ACTIVE + H_FRONT);
    localparam logic [H_CW-1:0] HS_END    = H_CW'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [V_CW-1:0] V_LAST    = V_CW'(V_TOTAL - 1);
    localparam logic [V_CW-1:0] V_ACT_END = V_CW'(V_ACTIVE);
    localparam logic [V_CW-1:0] VS_START  = V_CW'(V_ACTIVE + V_FRONT);
    localparam logic [V_CW-1:0] VS_END    = V_CW'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [H_CW-1:0] h_cnt;                     // position within line
    logic [V_CW-1:0] v_cnt;                     // line within frame
    logic            h_wrap;                    // last clock of a line
    logic            v_wrap;                    // last line of a frame
    logic            h_act;                     // h counter in visible range
    logic            v_act;                     // v counter in visible range
    logic            h_sync_win;                // h counter inside sync pulse
    logic            v_sync_win;                // v counter inside sync pulse

    assign h_wrap = (h_cnt == H_LAST);
    assign v_wrap = (v_cnt == V_LAST);

    // free running counter pair, v steps on h wrap
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
            if (v_wrap) begin
                v_cnt <= '0;                    // new frame
            end else begin
                v_cnt <= v_cnt + 1'b1;          // next line
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_act      = (h_cnt < H_ACT_END);
    assign v_act      = (v_cnt < V_ACT_END);
    assign h_sync_win = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign v_sync_win = (v_cnt >= VS_START) && (v_cnt < VS_END);

    // position and strobes registered together so they stay aligned
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_x     <= '0;
            o_y     <= '0;
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
        end else begin
            o_x     <= COORD_W'(h_cnt);         // blanking values alias, de is low there
            o_y     <= COORD_W'(v_cnt);
            o_hsync <= h_sync_win;
            o_vsync <= v_sync_win;              // changes on the line boundary
            o_de    <= h_act && v_act;
        end
    end

endmodule

//--- source/char_buffer.sv
`timescale 1ns/10ps

module char_buffer (
    input  logic                            i_clk,      // pixel clock, both ports
    input  logic                            i_wr_en,    // host write strobe
    input  logic [text_pkg::BUF_ADDR_W-1:0] i_wr_addr,  // {row, col}
    input  logic [text_pkg::CHAR_W-1:0]     i_wr_data,  // character byte
    input  logic [text_pkg::BUF_ADDR_W-1:0] i_rd_addr,  // display side {row, col}
    output logic [text_pkg::CHAR_W-1:0]     o_rd_data   // byte, one clock later
);
    import text_pkg::*;

    localparam int DEPTH = 1 << BUF_ADDR_W;     // 4096 cells

    // one byte per cell, contents undefined until the host fills it
    logic [CHAR_W-1:0] mem [DEPTH];

    // host port, single cycle write
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // display port, registered read
    // same-address collision returns the old byte
    always_ff @(posedge i_clk) begin
        o_rd_data <= mem[i_rd_addr];            // old value, nonblocking ordering
    end

endmodule

//--- source/glyph_renderer.sv
`timescale 1ns/10ps

module glyph_renderer (
    input  logic                           i_clk,       // pixel clock
    input  logic                           i_rst_n,     // sync reset, active low
    input  logic [text_pkg::CELL_BITS-1:0] i_cell_x,    // column inside the cell
    input  logic [text_pkg::CELL_BITS-1:0] i_cell_y,    // row inside the cell
    input  logic                           i_hsync,     // from timing gen
    input  logic                           i_vsync,     // from timing gen
    input  logic                           i_de,        // from timing gen
    input  logic [text_pkg::CHAR_W-1:0]    i_chr,       // buffer byte, 1 clock late
    output logic                           o_hsync,     // 2 clocks after input
    output logic                           o_vsync,
    output logic                           o_de,
    output logic                           o_pixel      // lit when high
);
    import text_pkg::*;

    localparam int IDX_W      = GLYPH_MSB - GLYPH_LSB + 1; // glyph index width
    localparam int RANGE_W    = RANGE_MSB - RANGE_LSB + 1; // blank field width
    localparam int GLYPHS     = 1 << IDX_W;                // 16 glyphs in rom
    localparam int PIX_IDX_W  = 2 * CELL_BITS;             // {row, col} in a glyph
    localparam int GLYPH_BITS = 1 << PIX_IDX_W;            // 64 bits per glyph

    // font rom, row 0 in the top byte, msb is the left pixel
    logic [GLYPH_BITS-1:0] font_rom [GLYPHS];

    initial begin
        $readmemh(FONT_FILE, font_rom);
    end

    logic [CELL_BITS-1:0]  cell_x_d1;           // matches buffer latency
    logic [CELL_BITS-1:0]  cell_y_d1;
    logic                  hsync_d1;            // first delay stage
    logic                  vsync_d1;
    logic                  de_d1;
    logic [IDX_W-1:0]      glyph_idx;           // low nibble of the byte
    logic [RANGE_W-1:0]    range_fld;           // bits 6:4
    logic                  inv;                 // inverse video flag
    logic                  blank;               // byte outside the font
    logic [GLYPH_BITS-1:0] glyph_word;          // selected glyph bitmap
    logic [PIX_IDX_W-1:0]  bit_idx;             // bit position in glyph word
    logic                  glyph_bit;           // raw font pixel
    logic                  pix_nxt;             // pixel before output register

    // stage 1, runs alongside the buffer read
    always_ff @(posedge i_clk) begin
        cell_x_d1 <= i_cell_x;
        cell_y_d1 <= i_cell_y;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            hsync_d1 <= 1'b0;
            vsync_d1 <= 1'b0;
            de_d1    <= 1'b0;
        end else begin
            hsync_d1 <= i_hsync;
            vsync_d1 <= i_vsync;
            de_d1    <= i_de;
        end
    end

    // byte decode, i_chr lines up with the stage 1 coordinates
    assign glyph_idx = i_chr[GLYPH_MSB:GLYPH_LSB];
    assign range_fld = i_chr[RANGE_MSB:RANGE_LSB];
    assign inv       = i_chr[INV_BIT];
    assign blank     = |range_fld;              // any bit set blanks the glyph

    assign glyph_word = font_rom[glyph_idx];
    assign bit_idx    = ~{cell_y_d1, cell_x_d1}; // 63 - (8*y + x)
    assign glyph_bit  = glyph_word[bit_idx];

    // blank clears the glyph, inverse then flips the whole cell
    assign pix_nxt = de_d1 & ((glyph_bit & ~blank) ^ inv);

    // stage 2, registered lookup and second sync delay
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
            o_pixel <= 1'b0;
        end else begin
            o_hsync <= hsync_d1;
            o_vsync <= vsync_d1;
            o_de    <= de_d1;
            o_pixel <= pix_nxt;                 // dark outside the active area
        end
    end

endmodule

//--- source/lcd_text_top.sv
`timescale 1ns/10ps

module lcd_text_top #(
    parameter int H_ACTIVE = lcd_timing_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = lcd_timing_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = lcd_timing_pkg::DEF_H_SYNC,
    parameter int H_BACK   = lcd_timing_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = lcd_timing_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = lcd_timing_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = lcd_timing_pkg::DEF_V_SYNC,
    parameter int V_BACK   = lcd_timing_pkg::DEF_V_BACK
) (
    input  logic                            i_clk,       // pixel clock
    input  logic                            i_rst_n,     // sync reset, active low
    input  logic                            i_wr_en,     // host write strobe
    input  logic [text_pkg::BUF_ADDR_W-1:0] i_wr_addr,   // {row, col}
    input  logic [text_pkg::CHAR_W-1:0]     i_wr_data,   // character byte
    output logic                            o_lcd_hsync,
    output logic                            o_lcd_vsync,
    output logic                            o_lcd_den,
    output logic [4:0]                      o_lcd_r,
    output logic [5:0]                      o_lcd_g,
    output logic [4:0]                      o_lcd_b
);
    import lcd_timing_pkg::*;
    import text_pkg::*;

    logic [COORD_W-1:0]    pix_x;               // timing gen position
    logic [COORD_W-1:0]    pix_y;
    logic                  tim_hsync;           // undelayed strobes
    logic                  tim_vsync;
    logic                  tim_de;
    logic [BUF_ADDR_W-1:0] rd_addr;             // cell under the beam
    logic [CHAR_W-1:0]     chr;                 // byte for that cell
    logic                  pixel;               // mono pixel, 2 clocks late

    lcd_timing_gen #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_timing (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .o_x     (pix_x),
        .o_y     (pix_y),
        .o_hsync (tim_hsync),
        .o_vsync (tim_vsync),
        .o_de    (tim_de)
    );

    // row from upper y bits, column from upper x bits
    assign rd_addr = {pix_y[COORD_W-1:CELL_BITS], pix_x[COORD_W-1:CELL_BITS]};

    char_buffer u_buffer (
        .i_clk     (i_clk),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (chr)
    );

    glyph_renderer u_render (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_cell_x (pix_x[CELL_BITS-1:0]),       // position inside the cell
        .i_cell_y (pix_y[CELL_BITS-1:0]),
        .i_hsync  (tim_hsync),
        .i_vsync  (tim_vsync),
        .i_de     (tim_de),
        .i_chr    (chr),
        .o_hsync  (o_lcd_hsync),
        .o_vsync  (o_lcd_vsync),
        .o_de     (o_lcd_den),
        .o_pixel  (pixel)
    );

    // white on black, every channel full or off
    assign o_lcd_r = {5{pixel}};
    assign o_lcd_g = {6{pixel}};
    assign o_lcd_b = {5{pixel}};

endmodule

//--- verification/tb_text_model.svh
`ifndef TB_TEXT_MODEL_SVH
`define TB_TEXT_MODEL_SVH

localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // clocks per line
localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // lines per frame
localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
localparam int COLS         = H_ACTIVE / 8;     // visible cells across
localparam int ROWS         = V_ACTIVE / 8;     // visible cell rows
localparam int RULE_HSYNC   = 0;
localparam int RULE_VSYNC   = 1;
localparam int RULE_HDE     = 2;
localparam int RULE_VDE     = 3;

logic [7:0]  shadow_mem [4096];                 // mirror of the character buffer
logic [63:0] model_font [16];                   // same image as the renderer rom

task automatic load_model_font();
    $readmemh(FONT_FILE, model_font);
endtask

task automatic shadow_write(input logic [11:0] addr, input logic [7:0] data);
    shadow_mem[addr] = data;                    // keeps mirror in step with host
endtask

// one counter rule evaluated at counter position n
function automatic logic rule_at(input int rule, input int n);
    case (rule)
        RULE_HSYNC: return (n >= H_ACTIVE + H_FRONT) && (n < H_ACTIVE + H_FRONT + H_SYNC);
        RULE_VSYNC: return (n >= V_ACTIVE + V_FRONT) && (n < V_ACTIVE + V_FRONT + V_SYNC);
        RULE_HDE:   return n < H_ACTIVE;
        default:    return n < V_ACTIVE;
    endcase
endfunction

// positions per period where a rule holds
function automatic int rule_count(input int rule, input int total);
    int n;
    int hits;
    hits = 0;
    for (n = 0; n < total; n++) begin
        if (rule_at(rule, n)) begin
            hits++;
        end
    end
    return hits;
endfunction

// pixel from the byte rule: blank clears, bit 7 flips
function automatic logic predict_pixel(input int px, input int py);
    logic [7:0]  chr;
    logic [63:0] glyph;
    logic [5:0]  bit_pos;
    logic        lit;
    chr     = shadow_mem[12'((py / 8) * 64 + (px / 8))];
    glyph   = model_font[chr[3:0]];
    bit_pos = 6'(63 - ((py % 8) * 8 + (px % 8))); // row 0 top byte, msb left
    lit     = glyph[bit_pos];
    if (chr[6:4] != 3'd0) begin
        lit = 1'b0;
    end
    if (chr[7]) begin
        lit = ~lit;
    end
    return lit;
endfunction

`endif

//--- verification/tb_lcd_text_top.sv
`timescale 1ns/10ps

module tb_lcd_text_top;
    import text_pkg::*;

    localparam int H_ACTIVE    = 64;            // 8 cells across
    localparam int H_FRONT     = 4;
    localparam int H_SYNC      = 4;
    localparam int H_BACK      = 8;
    localparam int V_ACTIVE    = 24;            // 3 cell rows
    localparam int V_FRONT     = 2;
    localparam int V_SYNC      = 2;
    localparam int V_BACK      = 4;
    localparam int SEL_HSYNC   = 0;
    localparam int SEL_VSYNC   = 1;
    localparam int SEL_DEN     = 2;
    localparam int LIVE_WRITES = 12;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_wr_en;
    logic [BUF_ADDR_W-1:0] i_wr_addr;
    logic [CHAR_W-1:0]     i_wr_data;
    logic                  o_lcd_hsync;
    logic                  o_lcd_vsync;
    logic                  o_lcd_den;
    logic [4:0]            o_lcd_r;
    logic [5:0]            o_lcd_g;
    logic [4:0]            o_lcd_b;

    int          value_errs;                    // pixel and colour mismatches
    int          timing_errs;                   // sync and enable mismatches
    int          timeout_errs;
    logic        timed_out;                     // stops the sequence early
    logic [31:0] lcg_state;

    `include "tb_text_model.svh"

    localparam int WAIT_LIMIT = 2 * FRAME_CYCLES;

    lcd_text_top #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_dut (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_en     (i_wr_en),
        .i_wr_addr   (i_wr_addr),
        .i_wr_data   (i_wr_data),
        .o_lcd_hsync (o_lcd_hsync),
        .o_lcd_vsync (o_lcd_vsync),
        .o_lcd_den   (o_lcd_den),
        .o_lcd_r     (o_lcd_r),
        .o_lcd_g     (o_lcd_g),
        .o_lcd_b     (o_lcd_b)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;              // 8 ns pixel clock
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // random byte of a chosen kind, glyph always random
    function automatic logic [7:0] make_cell_byte(input int kind);
        logic [31:0] r;
        logic [2:0]  range_f;
        r       = next_rand();
        range_f = r[22:20];
        if (range_f == 3'd0) begin
            range_f = 3'd1;                     // blank needs a nonzero field
        end
        case (kind)
            0:       return {1'b0, 3'b000, r[19:16]};
            1:       return {1'b1, 3'b000, r[19:16]};
            default: return {r[23], range_f, r[19:16]};
        endcase
    endfunction

    function automatic logic [11:0] cell_addr(input int row, input int col);
        return 12'(row * 64 + col);             // {row, col}
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SEL_HSYNC: return o_lcd_hsync;
            SEL_VSYNC: return o_lcd_vsync;
            default:   return o_lcd_den;
        endcase
    endfunction

    function automatic string sel_name(input int sel);
        case (sel)
            SEL_HSYNC: return "hsync";
            SEL_VSYNC: return "vsync";
            default:   return "den";
        endcase
    endfunction

    task automatic log_pixel_error(input string test, input logic [15:0] expected,
                                   input logic [15:0] actual);
        value_errs++;
        $display("[ERROR] %s: expected %04h, actual %04h", test, expected, actual);
    endtask

    task automatic log_timing_error(input string test, input int expected, input int actual);
        timing_errs++;
        $display("[ERROR] %s: expected %0d, actual %0d", test, expected, actual);
    endtask

    task automatic note_timeout(input string what);
        timeout_errs++;
        timed_out = 1'b1;
        $display("timeout: %s within %0d cycles", what, WAIT_LIMIT);
    endtask

    // step falling edges until a strobe sits at a level, cycles spent come back
    task automatic wait_level(input int sel, input logic level, output int cycles);
        cycles = 0;
        while (probe(sel) !== level) begin
            if (cycles >= WAIT_LIMIT) begin
                note_timeout($sformatf("%s never reached %0b", sel_name(sel), level));
                return;
            end
            @(negedge i_clk);
            cycles++;
        end
    endtask

    task automatic wait_rise(input int sel);
        int skip;
        wait_level(sel, 1'b0, skip);
        if (!timed_out) begin
            wait_level(sel, 1'b1, skip);
        end
    endtask

    // drive at the falling edge, lands on the next rising edge
    task automatic host_write(input logic [11:0] addr, input logic [7:0] data);
        i_wr_en   = 1'b1;
        i_wr_addr = addr;
        i_wr_data = data;
        shadow_write(addr, data);
        @(negedge i_clk);
        i_wr_en   = 1'b0;
    endtask

    task automatic check_reset();
        @(negedge i_clk);                       // cycle after release
        if ({o_lcd_hsync, o_lcd_vsync, o_lcd_den} !== 3'b000) begin
            log_timing_error("reset strobes", 0, int'({o_lcd_hsync, o_lcd_vsync, o_lcd_den}));
        end
        if ({o_lcd_r, o_lcd_g, o_lcd_b} !== 16'h0000) begin
            log_pixel_error("reset colour", 16'h0000, {o_lcd_r, o_lcd_g, o_lcd_b});
        end
    endtask

    task automatic check_line_timing();
        int width;
        int gap;
        wait_rise(SEL_HSYNC);
        repeat (4) begin
            if (timed_out) return;
            wait_level(SEL_HSYNC, 1'b0, width);     // pulse width
            if (timed_out) return;
            wait_level(SEL_HSYNC, 1'b1, gap);       // rest of the line
            if (width != rule_count(RULE_HSYNC, H_TOTAL)) begin
                log_timing_error("hsync width", rule_count(RULE_HSYNC, H_TOTAL), width);
            end
            if (width + gap != H_TOTAL) begin
                log_timing_error("line period", H_TOTAL, width + gap);
            end
        end
    endtask

    task automatic check_frame_timing();
        int   vs_cycles;
        int   run;
        int   lines;
        int   cycles;
        logic prev_den;
        wait_rise(SEL_VSYNC);
        if (timed_out) return;
        wait_level(SEL_VSYNC, 1'b0, vs_cycles);
        if (timed_out) return;
        if (vs_cycles != rule_count(RULE_VSYNC, V_TOTAL) * H_TOTAL) begin
            log_timing_error("vsync width", rule_count(RULE_VSYNC, V_TOTAL) * H_TOTAL,
                             vs_cycles);
        end
        run      = 0;
        lines    = 0;
        cycles   = 0;
        prev_den = 1'b0;
        while (o_lcd_vsync !== 1'b1) begin       // one frame of den lines
            if (cycles >= WAIT_LIMIT) begin
                note_timeout("vsync did not return");
                return;
            end
            if (o_lcd_den === 1'b1) begin
                run++;
            end else if (prev_den) begin
                lines++;
                if (run != rule_count(RULE_HDE, H_TOTAL)) begin
                    log_timing_error("den per line", rule_count(RULE_HDE, H_TOTAL), run);
                end
                run = 0;
            end
            prev_den = o_lcd_den;
            @(negedge i_clk);
            cycles++;
        end
        if (lines != rule_count(RULE_VDE, V_TOTAL)) begin
            log_timing_error("den lines", rule_count(RULE_VDE, V_TOTAL), lines);
        end
    endtask

    // starts in vertical blanking, compares the next whole frame
    task automatic check_frame(input string test);
        int          x;
        int          lines;
        int          cycles;
        logic        prev_den;
        logic        expected;
        logic [15:0] colour;
        x        = 0;
        lines    = 0;
        cycles   = 0;
        prev_den = 1'b0;
        while (lines < rule_count(RULE_VDE, V_TOTAL)) begin
            if (cycles >= WAIT_LIMIT) begin
                note_timeout($sformatf("%s frame incomplete", test));
                return;
            end
            colour = {o_lcd_r, o_lcd_g, o_lcd_b};
            if (o_lcd_den === 1'b1) begin
                expected = predict_pixel(x, lines);
                if (colour !== {16{expected}}) begin
                    log_pixel_error($sformatf("%s x=%0d y=%0d", test, x, lines),
                                    {16{expected}}, colour);
                end
                x++;
            end else begin
                if (colour !== 16'h0000) begin  // dark outside the active area
                    log_pixel_error($sformatf("%s blanking", test), 16'h0000, colour);
                end
                if (prev_den) begin
                    if (x != H_ACTIVE) begin
                        log_timing_error($sformatf("%s line width", test), H_ACTIVE, x);
                    end
                    lines++;
                    x = 0;
                end
            end
            prev_den = o_lcd_den;
            @(negedge i_clk);
            cycles++;
        end
    endtask

    task automatic fill_and_check();
        int row;
        int col;
        wait_rise(SEL_VSYNC);                   // vertical blanking begins
        if (timed_out) return;
        for (row = 0; row < ROWS; row++) begin
            for (col = 0; col < COLS; col++) begin
                host_write(cell_addr(row, col), make_cell_byte((row * COLS + col) % 3));
            end
        end
        check_frame("fill");
    endtask

    task automatic live_update();
        int          n;
        int          skip;
        logic [31:0] r;
        wait_rise(SEL_VSYNC);
        if (timed_out) return;
        wait_level(SEL_DEN, 1'b1, skip);        // inside the active frame
        if (timed_out) return;
        for (n = 0; n < LIVE_WRITES; n++) begin
            r = next_rand();
            repeat (int'(r >> 28)) @(negedge i_clk);
            host_write(cell_addr(int'((r >> 8) % ROWS), int'((r >> 16) % COLS)),
                       make_cell_byte(int'((r >> 4) % 3)));
        end
        wait_rise(SEL_VSYNC);                   // updates show from here on
        if (timed_out) return;
        check_frame("live update");
    endtask

    task automatic end_run();
        $display("errors: %0d value, %0d timing, %0d timeout",
                 value_errs, timing_errs, timeout_errs);
        if (value_errs + timing_errs + timeout_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_wr_en      = 1'b0;
        i_wr_addr    = '0;
        i_wr_data    = '0;
        value_errs   = 0;
        timing_errs  = 0;
        timeout_errs = 0;
        timed_out    = 1'b0;
        lcg_state    = 32'd30687;
        load_model_font();
        repeat (2) @(posedge i_clk);            // two rising edges in reset
        @(negedge i_clk);
        i_rst_n = 1'b1;
        check_reset();
        if (!timed_out) check_line_timing();
        if (!timed_out) check_frame_timing();
        if (!timed_out) fill_and_check();
        if (!timed_out) live_update();
        end_run();
    end

endmodule

//--- source/font_8x8.mem
// one glyph per line, 64-bit bitmap, digits 0-9 then A-F
// row 0 in the top byte, msb is the left pixel
3C666E7666663C00
1838181818187E00
3C66060C30607E00
3C66061C06663C00
0C1C3C6C7E0C0C00
7E607C0606663C00
3C607C6666663C00
7E060C1830303000
3C66663C66663C00
3C66663E060C3800
183C66667E666600
7C66667C66667C00
3C66606060663C00
786C6666666C7800
7E60607860607E00
7E60607860606000

//--- filelist.f
source/lcd_timing_pkg.sv
source/text_pkg.sv
source/lcd_timing_gen.sv
source/char_buffer.sv
source/glyph_renderer.sv
source/lcd_text_top.sv
+incdir+verification
verification/tb_lcd_text_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_lcd_text_top
RTL_TOP   := lcd_text_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
